// File: vlog.f
src/load_pkg.sv
src/load_entry_if.sv
src/data_ram.sv
src/load_issue.sv
src/load_fifo.sv
src/load_shifter.sv
src/load_writeback.sv
src/load_unit_top.sv
tests/load_unit_tb.sv

// File: Bender.yml
package:
  name: load_unit

sources:
  - src/load_pkg.sv
  - src/load_entry_if.sv
  - src/data_ram.sv
  - src/load_issue.sv
  - src/load_fifo.sv
  - src/load_shifter.sv
  - src/load_writeback.sv
  - src/load_unit_top.sv
  - target: test
    files:
      - tests/load_unit_tb.sv

// File: tests/load_unit_tb.sv
`timescale 1ns/1ps

module load_unit_tb;

	localparam int WORDS          = 256;
	localparam int NUM_DIRECTED   = 4 * 4 * 7;
	localparam int NUM_RANDOM     = 200;
	localparam int PARTIAL_WRITES = 8;
	localparam int PRELOAD_CYCLES = 5 + WORDS + PARTIAL_WRITES + 4;
	localparam int LIMIT_CYCLES   = (NUM_DIRECTED + NUM_RANDOM) * 20 + PRELOAD_CYCLES;

	logic                clk;
	logic                rst_n;
	logic                mem_we;
	logic [3:0]          mem_be;
	logic [7:0]          mem_waddr;
	load_pkg::word_t     mem_wdata;
	logic                req_valid;
	logic                req_ready;
	load_pkg::load_op_e  req_op;
	logic [9:0]          req_addr;
	load_pkg::word_t     req_rt_old;
	load_pkg::reg_idx_t  req_dest;
	logic                res_valid;
	logic                res_ready;
	load_pkg::word_t     res_data;
	load_pkg::reg_idx_t  res_dest;

	load_pkg::word_t     mem_model [0:WORDS-1];
	load_pkg::word_t     exp_data_q [$];
	load_pkg::reg_idx_t  exp_dest_q [$];
	logic                head_valid;
	load_pkg::word_t     head_data;
	load_pkg::reg_idx_t  head_dest;
	logic                last_accept;
	logic                steady_ready;
	logic [31:0]         rng_state;
	logic [31:0]         ready_state;

	load_unit_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_we     (mem_we),
		.mem_be     (mem_be),
		.mem_waddr  (mem_waddr),
		.mem_wdata  (mem_wdata),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_op     (req_op),
		.req_addr   (req_addr),
		.req_rt_old (req_rt_old),
		.req_dest   (req_dest),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.res_data   (res_data),
		.res_dest   (res_dest)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Expected register value built byte by byte.
	function automatic load_pkg::word_t model_result(input load_pkg::load_op_e op,
			input logic [1:0] off, input load_pkg::word_t w, input load_pkg::word_t old);
		int k;
		logic [7:0] b;
		logic [15:0] h;
		load_pkg::word_t r;
		k = off;
		b = w[8*k +: 8];
		h = w[16*off[1] +: 16];
		r = old;
		case (op)
			load_pkg::LB:  r = {{24{b[7]}}, b};
			load_pkg::LBU: r = {24'h000000, b};
			load_pkg::LH:  r = {{16{h[15]}}, h};
			load_pkg::LHU: r = {16'h0000, h};
			load_pkg::LW:  r = w;
			load_pkg::LWL: begin
				for (int j = 0; j <= k; j++) begin
					r[8*(3-k+j) +: 8] = w[8*j +: 8];
				end
			end
			default: begin
				for (int j = k; j <= 3; j++) begin
					r[8*(j-k) +: 8] = w[8*j +: 8];
				end
			end
		endcase
		return r;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic write_word(input logic [7:0] addr, input logic [3:0] be,
			input load_pkg::word_t data);
		mem_we    = 1'b1;
		mem_be    = be;
		mem_waddr = addr;
		mem_wdata = data;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				mem_model[addr][8*i +: 8] = data[8*i +: 8];
			end
		end
		@(negedge clk);
	endtask

	// Called on a falling edge, returns on the falling edge after acceptance.
	task automatic send_request(input load_pkg::load_op_e op, input logic [9:0] addr,
			input load_pkg::word_t rt_old, input load_pkg::reg_idx_t dest);
		req_valid  = 1'b1;
		req_op     = op;
		req_addr   = addr;
		req_rt_old = rt_old;
		req_dest   = dest;
		do begin
			@(negedge clk);
		end while (!last_accept);
		req_valid = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Scoreboard queue updated from the values seen just before each edge.
	always @(posedge clk) begin
		last_accept <= rst_n && req_valid && req_ready;
		if (rst_n) begin
			if (res_valid && res_ready && exp_data_q.size() != 0) begin
				void'(exp_data_q.pop_front());
				void'(exp_dest_q.pop_front());
			end
			if (req_valid && req_ready) begin
				exp_data_q.push_back(model_result(req_op, req_addr[1:0],
					mem_model[req_addr[9:2]], req_rt_old));
				exp_dest_q.push_back(req_dest);
			end
		end
		head_valid = (exp_data_q.size() != 0);
		head_data  = head_valid ? exp_data_q[0] : '0;
		head_dest  = head_valid ? exp_dest_q[0] : '0;
	end

	always @(negedge clk) begin
		if (!steady_ready) begin
			ready_state = xorshift(ready_state);
			res_ready   = (ready_state[2:0] < 3'd3);
		end
	end

	a_reset_idle: assert property (@(posedge clk) !rst_n |-> !res_valid)
		else stop_with_error("res_valid was high during reset");

	a_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !res_valid && req_ready)
		else stop_with_error("DUT was not idle and ready after reset");

	a_has_request: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> head_valid)
		else stop_with_error("A result appeared with no request outstanding");

	a_data_match: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> res_data == head_data)
		else stop_with_error($sformatf("Mismatch res_data expected %08h got %08h",
			$sampled(head_data), $sampled(res_data)));

	a_dest_match: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> res_dest == head_dest)
		else stop_with_error($sformatf("Mismatch res_dest expected %02h got %02h",
			$sampled(head_dest), $sampled(res_dest)));

	a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res_data) && $stable(res_dest))
		else stop_with_error("A held result changed before it was taken");

	a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
		steady_ready && req_valid && req_ready |-> ##2 res_valid && res_dest == $past(req_dest, 2))
		else stop_with_error("A result did not appear two edges after its request was accepted");

	a_ready_drop: assert property (@(posedge clk) disable iff (!rst_n)
		!req_ready |-> res_valid && !res_ready)
		else stop_with_error("req_ready was low while no result was held back");

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		stop_with_error($sformatf("Watchdog expired with %0d results outstanding",
			exp_data_q.size()));
	end

	initial begin
		rst_n        = 1'b0;
		mem_we       = 1'b0;
		mem_be       = 4'h0;
		mem_waddr    = '0;
		mem_wdata    = '0;
		req_valid    = 1'b0;
		req_op       = load_pkg::LW;
		req_addr     = '0;
		req_rt_old   = '0;
		req_dest     = '0;
		res_ready    = 1'b1;
		steady_ready = 1'b1;
		rng_state    = 32'h45c8;
		ready_state  = 32'h45c8;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Words 0..3 have bytes and halves with bit 7 and bit 15 both set and clear.
		write_word(8'd0, 4'hf, 32'h7f8001ff);
		write_word(8'd1, 4'hf, 32'h0af05cc3);
		write_word(8'd2, 4'hf, 32'h8001f00f);
		write_word(8'd3, 4'hf, 32'h12345678);
		for (int a = 4; a < WORDS; a++) begin
			rng_state = xorshift(rng_state);
			write_word(a[7:0], 4'hf, rng_state);
		end
		for (int n = 0; n < PARTIAL_WRITES; n++) begin
			rng_state = xorshift(rng_state);
			write_word(8'd4 + 8'(rng_state[15:8] % 252), rng_state[3:0], xorshift(rng_state));
		end
		mem_we = 1'b0;

		for (int w = 0; w < 4; w++) begin
			for (int off = 0; off < 4; off++) begin
				for (int op = 0; op < 7; op++) begin
					rng_state = xorshift(rng_state);
					send_request(load_pkg::load_op_e'(op), {w[7:0], off[1:0]},
						rng_state, rng_state[20:16]);
				end
			end
		end
		while (exp_data_q.size() != 0) begin
			@(negedge clk);
		end

		// Random back-pressure now fills the FIFO.
		@(posedge clk);
		steady_ready = 1'b0;
		@(negedge clk);
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rng_state = xorshift(rng_state);
			if (rng_state[28:24] == 5'd0) begin
				@(negedge clk);
			end
			send_request(load_pkg::load_op_e'(rng_state[31:16] % 7), rng_state[9:0],
				xorshift(rng_state), rng_state[14:10]);
		end
		while (exp_data_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (3) @(negedge clk);

		if (exp_data_q.size() == 0 && !res_valid) begin
			$display("Regression passed");
			$finish;
		end else begin
			stop_with_error("Results remained after the last request drained");
		end
	end

endmodule

// File: src/load_unit_top.sv
`timescale 1ns/1ps

module load_unit_top #(
	parameter int ADDR_WIDTH = 8,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  mem_we,
	input  logic [3:0]            mem_be,
	input  logic [ADDR_WIDTH-1:0] mem_waddr,
	input  load_pkg::word_t       mem_wdata,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  load_pkg::load_op_e    req_op,
	input  logic [ADDR_WIDTH+1:0] req_addr,
	input  load_pkg::word_t       req_rt_old,
	input  load_pkg::reg_idx_t    req_dest,
	output logic                  res_valid,
	input  logic                  res_ready,
	output load_pkg::word_t       res_data,
	output load_pkg::reg_idx_t    res_dest
);

	logic                  rd_en;
	logic [ADDR_WIDTH-1:0] rd_addr;
	load_pkg::word_t       rd_data;

	load_entry_if issue_to_fifo ();
	load_entry_if fifo_to_wb ();

	data_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
		.clk     (clk),
		.we      (mem_we),
		.be      (mem_be),
		.waddr   (mem_waddr),
		.wdata   (mem_wdata),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	load_issue #(.ADDR_WIDTH(ADDR_WIDTH)) u_issue (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_op     (req_op),
		.req_addr   (req_addr),
		.req_rt_old (req_rt_old),
		.req_dest   (req_dest),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.ent        (issue_to_fifo.src)
	);

	load_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (issue_to_fifo.sink),
		.pop   (fifo_to_wb.src)
	);

	load_writeback u_writeback (
		.ent       (fifo_to_wb.sink),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_data  (res_data),
		.res_dest  (res_dest)
	);

endmodule

// File: src/load_writeback.sv
`timescale 1ns/1ps

module load_writeback (
	load_entry_if.sink          ent,
	output logic                res_valid,
	input  logic                res_ready,
	output load_pkg::word_t     res_data,
	output load_pkg::reg_idx_t  res_dest
);

	load_pkg::word_t aligned;

	load_shifter u_shifter (
		.op     (ent.op),
		.offset (ent.offset),
		.word   (ent.word),
		.rt_old (ent.rt_old),
		.data   (aligned)
	);

	// The head leaves whenever the consumer takes the result.
	assign ent.ready = res_ready;

	assign res_valid = ent.valid;
	assign res_data  = aligned;
	assign res_dest  = ent.dest;

	// No clock reaches this stage, so the opcode check is deferred.
	always_comb begin
		a_op_defined: assert #0 (ent.valid !== 1'b1 || ent.op inside {
			load_pkg::LB,
			load_pkg::LH,
			load_pkg::LWL,
			load_pkg::LW,
			load_pkg::LBU,
			load_pkg::LHU,
			load_pkg::LWR
		})
			else $error("load_writeback head holds an undefined opcode");
	end

endmodule

// File: src/load_shifter.sv
`timescale 1ns/1ps

module load_shifter (
	input  load_pkg::load_op_e   op,
	input  load_pkg::byte_off_t  offset,
	input  load_pkg::word_t      word,
	input  load_pkg::word_t      rt_old,
	output load_pkg::word_t      data
);

	load_pkg::byte_off_t  inv_off;
	load_pkg::word_t      byte_down;
	load_pkg::word_t      half_down;
	load_pkg::word_t      merge_src;
	load_pkg::word_t      lane_bits;
	load_pkg::word_t      merged;
	logic [3:0]           lane_mask;

	assign inv_off = 2'd3 - offset;

	// Addressed byte or halfword moved down to bit 0.
	assign byte_down = word >> {offset, 3'b000};
	assign half_down = word >> {offset[1], 4'b0000};

	// LWL fills from the top, LWR from the bottom.
	always_comb begin
		lane_mask = 4'b0000;
		merge_src = word;
		if (op == load_pkg::LWL) begin
			lane_mask = 4'b1111 << inv_off;
			merge_src = word << {inv_off, 3'b000};
		end else if (op == load_pkg::LWR) begin
			lane_mask = 4'b1111 >> offset;
			merge_src = word >> {offset, 3'b000};
		end
	end

	always_comb begin
		for (int i = 0; i < load_pkg::WORD_BYTES; i++) begin
			lane_bits[8*i +: 8] = {8{lane_mask[i]}};
		end
	end

	// Lanes outside the mask keep the old register bytes.
	assign merged = (merge_src & lane_bits) | (rt_old & ~lane_bits);

	always_comb begin
		case (op)
			load_pkg::LB: begin
				data = {{24{byte_down[7]}}, byte_down[7:0]};
			end
			load_pkg::LBU: begin
				data = {24'h000000, byte_down[7:0]};
			end
			load_pkg::LH: begin
				data = {{16{half_down[15]}}, half_down[15:0]};
			end
			load_pkg::LHU: begin
				data = {16'h0000, half_down[15:0]};
			end
			load_pkg::LWL, load_pkg::LWR: begin
				data = merged;
			end
			default: begin
				data = word;
			end
		endcase
	end

endmodule

// File: src/load_fifo.sv
`timescale 1ns/1ps

module load_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	load_entry_if.sink push,
	load_entry_if.src  pop
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	load_pkg::load_op_e   op_mem     [0:FIFO_DEPTH-1];
	load_pkg::byte_off_t  off_mem    [0:FIFO_DEPTH-1];
	load_pkg::word_t      word_mem   [0:FIFO_DEPTH-1];
	load_pkg::word_t      rt_old_mem [0:FIFO_DEPTH-1];
	load_pkg::reg_idx_t   dest_mem   [0:FIFO_DEPTH-1];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == CNT_W'(FIFO_DEPTH));
	// A full buffer still takes an entry when the head leaves.
	assign push.ready = !full || pop.ready;
	assign pop.valid  = (count != '0);
	assign do_push = push.valid && push.ready;
	assign do_pop  = pop.valid && pop.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			op_mem[wr_ptr]     <= push.op;
			off_mem[wr_ptr]    <= push.offset;
			word_mem[wr_ptr]   <= push.word;
			rt_old_mem[wr_ptr] <= push.rt_old;
			dest_mem[wr_ptr]   <= push.dest;
		end
	end

	assign pop.op     = op_mem[rd_ptr];
	assign pop.offset = off_mem[rd_ptr];
	assign pop.word   = word_mem[rd_ptr];
	assign pop.rt_old = rt_old_mem[rd_ptr];
	assign pop.dest   = dest_mem[rd_ptr];

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= CNT_W'(FIFO_DEPTH))
		else $error("load_fifo count above depth");

endmodule

// File: src/load_issue.sv
`timescale 1ns/1ps

module load_issue #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  load_pkg::load_op_e    req_op,
	input  logic [ADDR_WIDTH+1:0] req_addr,
	input  load_pkg::word_t       req_rt_old,
	input  load_pkg::reg_idx_t    req_dest,
	output logic                  rd_en,
	output logic [ADDR_WIDTH-1:0] rd_addr,
	input  load_pkg::word_t       rd_data,
	load_entry_if.src             ent
);

	logic                 valid_q;
	logic                 accept;
	load_pkg::load_op_e   op_q;
	load_pkg::byte_off_t  off_q;
	load_pkg::word_t      rt_old_q;
	load_pkg::reg_idx_t   dest_q;

	// Free when empty or when the held entry leaves this cycle.
	assign req_ready = !valid_q || ent.ready;
	assign accept    = req_valid && req_ready;

	assign rd_en   = accept;
	assign rd_addr = req_addr[ADDR_WIDTH+1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (accept) begin
			valid_q <= 1'b1;
		end else if (ent.ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_q     <= req_op;
			off_q    <= req_addr[1:0];
			rt_old_q <= req_rt_old;
			dest_q   <= req_dest;
		end
	end

	assign ent.valid  = valid_q;
	assign ent.op     = op_q;
	assign ent.offset = off_q;
	assign ent.rt_old = rt_old_q;
	assign ent.dest   = dest_q;
	// The RAM keeps the fetched word while no new read is enabled.
	assign ent.word   = rd_data;

	a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		ent.valid && !ent.ready |=>
			ent.valid && $stable({ent.op, ent.offset, ent.word, ent.rt_old, ent.dest}))
		else $error("load_issue entry changed while stalled");

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                  clk,
	input  logic                  we,
	input  logic [3:0]            be,
	input  logic [ADDR_WIDTH-1:0] waddr,
	input  load_pkg::word_t       wdata,
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output load_pkg::word_t       rd_data
);

	localparam int WORDS = 2 ** ADDR_WIDTH;

	load_pkg::word_t mem [0:WORDS-1];

	// Byte lane writes.
	always_ff @(posedge clk) begin
		if (we) begin
			for (int i = 0; i < load_pkg::WORD_BYTES; i++) begin
				if (be[i]) begin
					mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// Read output holds its value unless a read is enabled.
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	a_write_known: assert property (@(posedge clk) we |-> !$isunknown({be, wdata}))
		else $error("data_ram write with unknown data or byte enables");

endmodule

// File: src/load_entry_if.sv
`timescale 1ns/1ps

interface load_entry_if;

	logic                 valid;
	logic                 ready;
	load_pkg::load_op_e   op;
	load_pkg::byte_off_t  offset;
	load_pkg::word_t      word;
	load_pkg::word_t      rt_old;
	load_pkg::reg_idx_t   dest;

	modport src (
		output valid,
		output op,
		output offset,
		output word,
		output rt_old,
		output dest,
		input  ready
	);

	modport sink (
		input  valid,
		input  op,
		input  offset,
		input  word,
		input  rt_old,
		input  dest,
		output ready
	);

endinterface

// File: src/load_pkg.sv
package load_pkg;

	// Load opcodes in selector order.
	typedef enum logic [2:0] {
		LB  = 3'd0,
		LH  = 3'd1,
		LWL = 3'd2,
		LW  = 3'd3,
		LBU = 3'd4,
		LHU = 3'd5,
		LWR = 3'd6
	} load_op_e;

	// One memory or register data word.
	typedef logic [31:0] word_t;

	// Destination register index.
	typedef logic [4:0] reg_idx_t;

	// Byte position inside a word, 0 is bits 7..0.
	typedef logic [1:0] byte_off_t;

	localparam int WORD_BYTES = 4;

endpackage
